/* logic/video_timing_pkg.sv */
package video_timing_pkg;

	// raster position
	// 10 bits covers up to 1023 clocks per line or lines per frame
	typedef logic [9:0] count_t;

	// video memory word address, 16-bit words
	typedef logic [22:0] vaddr_t;

	// one memory word, also one group of 16 mono pixels
	typedef logic [15:0] word_t;

	// phase of the shared cpu/video bus cycle
	typedef logic [3:0] bus_slot_t;

	// one colour channel on the vga connector
	typedef logic [5:0] color_t;

	// read window runs this many clocks ahead of display enable
	// one word of pixels: fetched, then loaded into the shifter
	localparam count_t H_PRE = 10'd16;

	// bus phase at which memory data is valid
	localparam bus_slot_t FETCH_SLOT = 4'd3;

	// raster state as seen by fetch and shifter
	typedef struct packed {
		// horizontal position in clocks
		count_t hcnt;
		// vertical position in lines
		count_t vcnt;
		// sync pulses, active high here
		logic   hs;
		logic   vs;
		// pixel window, already shifted by H_PRE
		logic   de;
		// frame end markers, used for the address rewind
		logic   hmax;
		logic   vmax;
	} raster_t;

endpackage

/* logic/video_regs_pkg.sv */
package video_regs_pkg;

	// word offset within the video register block
	typedef logic [5:0] reg_addr_t;

	// cpu data bus width
	typedef logic [15:0] reg_data_t;

	// cpu side of the register block
	// uds and lds are 68000 style byte strobes, active low
	typedef struct packed {
		// block selected
		logic      sel;
		// 1 = read, 0 = write
		logic      rw;
		// upper byte lane, bits 15:8
		logic      uds;
		// lower byte lane, bits 7:0
		logic      lds;
		reg_addr_t addr;
		reg_data_t din;
	} reg_bus_t;

	// base address high byte, word address bits 22:15
	localparam reg_addr_t REG_BASE_HI   = 6'h00;
	// base address mid byte, word address bits 14:7
	localparam reg_addr_t REG_BASE_MID  = 6'h01;
	// live fetch address, read only
	localparam reg_addr_t REG_VADDR_HI  = 6'h02;
	localparam reg_addr_t REG_VADDR_MID = 6'h03;
	localparam reg_addr_t REG_VADDR_LO  = 6'h04;
	// palette entry 0, only blue bits 2:0 kept in mono
	localparam reg_addr_t REG_PALETTE0  = 6'h20;

	// default screen at byte 0x10000, word 0x8000
	localparam logic [22:0] BASE_ADDR_RESET = 23'h008000;

	// blue 7 -> bit 0 set, so set data bits show dark
	// the usual ST look, black on white
	localparam logic [2:0] PALETTE0_BLUE_RESET = 3'd7;

endpackage

/* logic/video_timing.sv */
`timescale 1ns/1ps

module video_timing import video_timing_pkg::*; #(
	parameter int H_ACT = 640,
	parameter int H_FP  = 24,
	parameter int H_S   = 40,
	parameter int H_BP  = 128,
	parameter int V_ACT = 400,
	parameter int V_FP  = 55,
	parameter int V_S   = 3,
	parameter int V_BP  = 73
) (
	input  logic    clk,
	input  logic    ss,
	output raster_t raster
);

	// line and frame length
	localparam count_t H_LAST = count_t'(H_ACT + H_FP + H_S + H_BP - 1);
	localparam count_t V_LAST = count_t'(V_ACT + V_FP + V_S + V_BP - 1);

	// hsync sits H_PRE later, like the pixels it frames
	localparam count_t HS_ON  = count_t'(H_ACT + H_FP + int'(H_PRE));
	localparam count_t HS_OFF = count_t'(H_ACT + H_FP + H_S + int'(H_PRE));

	// vsync has no prefetch offset
	localparam count_t VS_ON  = count_t'(V_ACT + V_FP);
	localparam count_t VS_OFF = count_t'(V_ACT + V_FP + V_S);

	// visible window
	localparam count_t DE_ON  = H_PRE;
	localparam count_t DE_OFF = count_t'(H_ACT + int'(H_PRE));
	localparam count_t V_END  = count_t'(V_ACT);

	count_t hcnt;
	count_t vcnt;

	// counters
	// reset keeps them in step with the bus phase counter
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			// next line, wrap at frame end
			if (vcnt == V_LAST) begin
				vcnt <= '0;
			end else begin
				vcnt <= vcnt + 10'd1;
			end
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	// decode, all combinational on the counters
	always_comb begin
		raster.hcnt = hcnt;
		raster.vcnt = vcnt;
		raster.hs   = (hcnt >= HS_ON) && (hcnt < HS_OFF);
		raster.vs   = (vcnt >= VS_ON) && (vcnt < VS_OFF);
		raster.de   = (hcnt >= DE_ON) && (hcnt < DE_OFF) && (vcnt < V_END);
		// well past the last pixel, safe point to rewind the address
		raster.hmax = (hcnt == HS_ON);
		raster.vmax = (vcnt == VS_ON);
	end

endmodule

/* logic/video_regs.sv */
`timescale 1ns/1ps

module video_regs import video_timing_pkg::*, video_regs_pkg::*; (
	input  logic      clk,
	input  logic      ss,
	input  reg_bus_t  reg_bus,
	input  vaddr_t    vaddr,
	output reg_data_t reg_dout,
	output vaddr_t    base_addr,
	output logic      invert
);

	// base address bytes, word address bits 22:15 and 14:7
	logic [7:0] base_hi;
	logic [7:0] base_mid;

	// palette 0 blue, only bit 0 matters for mono
	logic [2:0] pal0_blue;

	// strobes
	// all mono registers live in the low byte lane
	// nothing decodes uds in this mode
	logic wr_lo;
	logic rd_lo;

	assign wr_lo = reg_bus.sel && !reg_bus.rw && !reg_bus.lds;
	assign rd_lo = reg_bus.sel && reg_bus.rw && !reg_bus.lds;

	// register writes
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_hi   <= BASE_ADDR_RESET[22:15];
			base_mid  <= BASE_ADDR_RESET[14:7];
			pal0_blue <= PALETTE0_BLUE_RESET;
		end else if (wr_lo) begin
			case (reg_bus.addr)
				REG_BASE_HI: begin
					base_hi <= reg_bus.din[7:0];
				end
				REG_BASE_MID: begin
					base_mid <= reg_bus.din[7:0];
				end
				REG_PALETTE0: begin
					pal0_blue <= reg_bus.din[2:0];
				end
				// vaddr bytes are read only
				default: begin
				end
			endcase
		end
	end

	// screen starts on a 128 word (256 byte) boundary
	assign base_addr = {base_hi, base_mid, 7'b0};

	// blue bit 0 flips the pixel sense
	assign invert = pal0_blue[0];

	// readback, zero when not addressed
	always_comb begin
		reg_dout = '0;
		if (rd_lo) begin
			case (reg_bus.addr)
				REG_BASE_HI: begin
					reg_dout = {8'h00, base_hi};
				end
				REG_BASE_MID: begin
					reg_dout = {8'h00, base_mid};
				end
				REG_VADDR_HI: begin
					reg_dout = {8'h00, vaddr[22:15]};
				end
				REG_VADDR_MID: begin
					reg_dout = {8'h00, vaddr[14:7]};
				end
				// low byte is a byte address, hence the shift
				REG_VADDR_LO: begin
					reg_dout = {8'h00, vaddr[6:0], 1'b0};
				end
				REG_PALETTE0: begin
					reg_dout = {13'h0000, pal0_blue};
				end
				default: begin
					reg_dout = '0;
				end
			endcase
		end
	end

endmodule

/* logic/video_fetch.sv */
`timescale 1ns/1ps

module video_fetch import video_timing_pkg::*, video_regs_pkg::*; #(
	parameter int H_ACT = 640,
	parameter int V_ACT = 400
) (
	input  logic      clk,
	input  logic      ss,
	input  raster_t   raster,
	input  bus_slot_t bus_cycle,
	input  word_t     data,
	input  vaddr_t    base_addr,
	output logic      read,
	output vaddr_t    vaddr,
	output word_t     fetch_word
);

	// read window ends H_PRE before the pixels do
	localparam count_t H_END = count_t'(H_ACT);
	localparam count_t V_END = count_t'(V_ACT);

	logic fetch;

	// video owns bus phases 0..3 of every 16
	// one word per slot, 16 pixels, so the window keeps pace
	assign read = (bus_cycle[3:2] == 2'b00) &&
		(raster.hcnt < H_END) && (raster.vcnt < V_END);

	// data valid at the end of the slot
	// memory has to be ready, no wait states
	assign fetch = read && (bus_cycle == FETCH_SLOT);

	// word latch, picked up by the shifter at hcnt[3:0] == 15
	always_ff @(posedge clk) begin
		if (fetch) begin
			fetch_word <= data;
		end
	end

	// address counter
	// base register is held at the same value while ss is high
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			vaddr <= BASE_ADDR_RESET;
		end else if (fetch) begin
			vaddr <= vaddr + 23'd1;
		end else if (!read && raster.hmax && raster.vmax) begin
			// frame end, new base takes effect here
			vaddr <= base_addr;
		end
	end

endmodule

/* logic/video_shifter.sv */
`timescale 1ns/1ps

module video_shifter import video_timing_pkg::*; (
	input  logic    clk,
	input  logic    ss,
	input  raster_t raster,
	input  word_t   fetch_word,
	input  logic    invert,
	output color_t  video_r,
	output color_t  video_g,
	output color_t  video_b,
	output logic    hs_n,
	output logic    vs_n
);

	// pixel shift register, msb goes out first
	word_t tx;
	logic  pixel;

	// reload on the last clock of each 16-clock group
	// first bit then lines up with de going high
	always_ff @(posedge clk) begin
		if (&raster.hcnt[3:0]) begin
			tx <= fetch_word;
		end else begin
			tx <= {tx[14:0], 1'b0};
		end
	end

	// polarity, then blank outside the window
	assign pixel = (tx[15] ^ invert) && raster.de;

	// output stage
	// mono has no grey levels, all channels follow the one bit
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
			hs_n    <= 1'b1;
			vs_n    <= 1'b1;
		end else begin
			video_r <= {6{pixel}};
			video_g <= {6{pixel}};
			video_b <= {6{pixel}};
			// negative sync for the 72 Hz mono monitor
			hs_n    <= !raster.hs;
			vs_n    <= !raster.vs;
		end
	end

endmodule

/* logic/video_top.sv */
`timescale 1ns/1ps

module video_top import video_timing_pkg::*, video_regs_pkg::*; #(
	// 640x400 mono at about 72 Hz, 32 MHz pixel clock
	parameter int H_ACT = 640,
	parameter int H_FP  = 24,
	parameter int H_S   = 40,
	parameter int H_BP  = 128,
	parameter int V_ACT = 400,
	parameter int V_FP  = 55,
	parameter int V_S   = 3,
	parameter int V_BP  = 73
) (
	input  logic      clk,
	input  logic      ss,
	// cpu register port
	input  reg_bus_t  reg_bus,
	output reg_data_t reg_dout,
	// memory port
	input  bus_slot_t bus_cycle,
	input  word_t     data,
	output logic      read,
	output vaddr_t    vaddr,
	// monitor
	output color_t    video_r,
	output color_t    video_g,
	output color_t    video_b,
	output logic      hs_n,
	output logic      vs_n
);

	raster_t raster;
	vaddr_t  base_addr;
	logic    invert;
	word_t   fetch_word;

	// raster generator, only timing in the design
	video_timing #(
		.H_ACT(H_ACT), .H_FP(H_FP), .H_S(H_S), .H_BP(H_BP),
		.V_ACT(V_ACT), .V_FP(V_FP), .V_S(V_S), .V_BP(V_BP)
	) timing0 (
		.clk    (clk),
		.ss     (ss),
		.raster (raster)
	);

	// base address and polarity, plus vaddr readback
	video_regs regs0 (
		.clk       (clk),
		.ss        (ss),
		.reg_bus   (reg_bus),
		.vaddr     (vaddr),
		.reg_dout  (reg_dout),
		.base_addr (base_addr),
		.invert    (invert)
	);

	// memory reads, one word ahead of the shifter
	video_fetch #(
		.H_ACT(H_ACT),
		.V_ACT(V_ACT)
	) fetch0 (
		.clk        (clk),
		.ss         (ss),
		.raster     (raster),
		.bus_cycle  (bus_cycle),
		.data       (data),
		.base_addr  (base_addr),
		.read       (read),
		.vaddr      (vaddr),
		.fetch_word (fetch_word)
	);

	// serializer and output registers
	video_shifter shifter0 (
		.clk        (clk),
		.ss         (ss),
		.raster     (raster),
		.fetch_word (fetch_word),
		.invert     (invert),
		.video_r    (video_r),
		.video_g    (video_g),
		.video_b    (video_b),
		.hs_n       (hs_n),
		.vs_n       (vs_n)
	);

endmodule

/* testbench/tb_video.sv */
`timescale 1ns/1ps

module tb_video import video_timing_pkg::*, video_regs_pkg::*; ();

	// small raster of 64 clocks per line and 10 lines per frame
	localparam int H_ACT = 32;
	localparam int H_FP  = 8;
	localparam int H_S   = 8;
	localparam int H_BP  = 16;
	localparam int V_ACT = 4;
	localparam int V_FP  = 2;
	localparam int V_S   = 2;
	localparam int V_BP  = 2;
	localparam int H_TOT = H_ACT + H_FP + H_S + H_BP;
	localparam int V_TOT = V_ACT + V_FP + V_S + V_BP;
	localparam int FRAME = H_TOT * V_TOT;
	// one word per 16 pixels
	localparam int WORDS = (H_ACT / 16) * V_ACT;
	// base bytes written by the register table
	localparam logic [7:0] NEW_HI  = 8'h02;
	localparam logic [7:0] NEW_MID = 8'h40;
	localparam reg_bus_t IDLE = '{sel: 1'b0, rw: 1'b1, uds: 1'b1, lds: 1'b1, addr: '0, din: '0};

	// one table row holds a bus cycle and its expected readback
	typedef struct packed {
		reg_bus_t  bus;
		reg_data_t want;
	} reg_op_t;

	logic      clk = 1'b0;
	logic      ss = 1'b1;
	reg_bus_t  reg_bus = IDLE;
	bus_slot_t bus_cycle = '0;
	word_t     data = '0;
	reg_data_t reg_dout;
	logic      read;
	vaddr_t    vaddr;
	color_t    video_r;
	color_t    video_g;
	color_t    video_b;
	logic      hs_n;
	logic      vs_n;

	int        seed = 90548;
	word_t     mask;
	int        tests = 0;
	int        errors = 0;
	reg_op_t   op_q[$];
	string     name_q[$];

	video_top #(
		.H_ACT(H_ACT), .H_FP(H_FP), .H_S(H_S), .H_BP(H_BP),
		.V_ACT(V_ACT), .V_FP(V_FP), .V_S(V_S), .V_BP(V_BP)
	) dut0 (
		.clk(clk), .ss(ss), .reg_bus(reg_bus), .reg_dout(reg_dout),
		.bus_cycle(bus_cycle), .data(data), .read(read), .vaddr(vaddr),
		.video_r(video_r), .video_g(video_g), .video_b(video_b),
		.hs_n(hs_n), .vs_n(vs_n)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// memory model word pattern folds in every address bit
	function automatic word_t mem_word(input vaddr_t a);
		return a[15:0] ^ {9'h000, a[22:16]} ^ mask;
	endfunction

	function automatic int set_bits(input word_t w);
		int n;
		n = 0;
		for (int b = 0; b < 16; b++) begin
			n += w[b] ? 1 : 0;
		end
		return n;
	endfunction

	// bus phase runs in step with hcnt once ss drops
	// address only moves at the fetch edge, so data is ready a clock early
	always @(posedge clk) begin
		if (ss) begin
			bus_cycle <= '0;
		end else begin
			bus_cycle <= bus_cycle + 4'd1;
		end
		data <= mem_word(vaddr);
	end

	task automatic report_and_finish();
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("timeout: %s never reached the expected level", what);
		report_and_finish();
	endtask

	task automatic tally(input string name, input logic ok, input string want, input string got);
		tests++;
		if (ok) begin
			$display("pass  %s = %s", name, got);
		end else begin
			errors++;
			$display("ERROR %s expected %s actual %s", name, want, got);
		end
	endtask

	task automatic check_reg(input string name, input reg_data_t want, input reg_data_t got);
		tally(name, got === want, $sformatf("%h", want), $sformatf("%h", got));
	endtask

	task automatic check_addr(input string name, input vaddr_t want, input vaddr_t got);
		tally(name, got === want, $sformatf("%h", want), $sformatf("%h", got));
	endtask

	task automatic check_count(input string name, input int want, input int got);
		tally(name, got == want, $sformatf("%0d", want), $sformatf("%0d", got));
	endtask

	task automatic check_color(input string name, input color_t want, input color_t got);
		tally(name, got === want, $sformatf("%h", want), $sformatf("%h", got));
	endtask

	task automatic add_op(input string name, input logic sel, input logic rw, input logic lds,
		input reg_addr_t addr, input reg_data_t din, input reg_data_t want);
		reg_op_t op;
		op.bus = '{sel: sel, rw: rw, uds: 1'b1, lds: lds, addr: addr, din: din};
		op.want = want;
		op_q.push_back(op);
		name_q.push_back(name);
	endtask

	// one cpu cycle with the combinational readback sampled mid cycle
	task automatic reg_access(input reg_bus_t bus, output reg_data_t dout);
		@(posedge clk);
		reg_bus <= bus;
		@(negedge clk);
		dout = reg_dout;
		@(posedge clk);
		reg_bus <= IDLE;
	endtask

	task automatic read_back(input string name, input reg_addr_t addr, input reg_data_t want);
		reg_data_t dout;
		reg_access('{sel: 1'b1, rw: 1'b1, uds: 1'b1, lds: 1'b0, addr: addr, din: '0}, dout);
		check_reg(name, want, dout);
	endtask

	function automatic logic sync_level(input logic vert);
		return vert ? vs_n : hs_n;
	endfunction

	// clocks until the sync output shows level
	task automatic count_until(input logic vert, input logic level, output int n);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (sync_level(vert) !== level && n <= 2 * FRAME);
		if (sync_level(vert) !== level) begin
			timed_out(vert ? "vs_n" : "hs_n");
		end
	endtask

	task automatic measure_sync(input logic vert, input int low_want, input int period_want);
		int low;
		int high;
		// line up on a falling edge
		count_until(vert, 1'b1, low);
		count_until(vert, 1'b0, low);
		count_until(vert, 1'b1, low);
		count_until(vert, 1'b0, high);
		check_count(vert ? "vs_n low width" : "hs_n low width", low_want, low);
		check_count(vert ? "vs_n period" : "hs_n period", period_want, low + high);
	endtask

	// one frame starting at a vs_n fall
	// the address rewind lands inside it
	task automatic measure_frame(input string tag, input vaddr_t base, input logic inv);
		int     fetches;
		int     ones;
		int     bits;
		int     skip;
		logic   seen;
		vaddr_t first;
		color_t stray;
		color_t drift;
		fetches = 0;
		ones = 0;
		bits = 0;
		seen = 1'b0;
		first = '0;
		stray = '0;
		drift = '0;
		count_until(1'b1, 1'b1, skip);
		count_until(1'b1, 1'b0, skip);
		for (int i = 0; i < FRAME; i++) begin
			@(negedge clk);
			if (read && bus_cycle == FETCH_SLOT) begin
				fetches++;
			end
			if (read && !seen) begin
				seen = 1'b1;
				first = vaddr;
			end
			if (video_r == 6'h3f) begin
				ones++;
			end else begin
				stray |= video_r | video_g | video_b;
			end
			drift |= (video_g ^ video_r) | (video_b ^ video_r);
		end
		for (int w = 0; w < WORDS; w++) begin
			bits += set_bits(mem_word(base + vaddr_t'(w)));
		end
		check_count({tag, " fetches"}, WORDS, fetches);
		check_addr({tag, " start address"}, base, first);
		check_addr({tag, " end address"}, base + vaddr_t'(WORDS), vaddr);
		check_count({tag, " lit pixels"}, inv ? H_ACT * V_ACT - bits : bits, ones);
		check_color({tag, " blank colour"}, '0, stray);
		check_color({tag, " green and blue follow red"}, '0, drift);
	endtask

	initial begin
		reg_data_t dout;
		vaddr_t    new_base;
		vaddr_t    last;
		mask = word_t'($random(seed));
		new_base = vaddr_t'({NEW_HI, NEW_MID, 7'b0});
		last = new_base + vaddr_t'(WORDS);

		// name, sel, rw, lds, addr, din, expected readback
		add_op("read without sel", 1'b0, 1'b1, 1'b0, REG_BASE_HI, 16'h0000, 16'h0000);
		add_op("reset base hi", 1'b1, 1'b1, 1'b0, REG_BASE_HI, 16'h0000, 16'h0001);
		add_op("reset base mid", 1'b1, 1'b1, 1'b0, REG_BASE_MID, 16'h0000, 16'h0000);
		add_op("reset palette0", 1'b1, 1'b1, 1'b0, REG_PALETTE0, 16'h0000, 16'h0007);
		add_op("write base hi", 1'b1, 1'b0, 1'b0, REG_BASE_HI, {8'h00, NEW_HI}, 16'h0000);
		add_op("write base mid", 1'b1, 1'b0, 1'b0, REG_BASE_MID, {8'h00, NEW_MID}, 16'h0000);
		// write with the lane off must be ignored
		add_op("write base hi lds off", 1'b1, 1'b0, 1'b1, REG_BASE_HI, 16'h00ff, 16'h0000);
		add_op("write palette0", 1'b1, 1'b0, 1'b0, REG_PALETTE0, 16'h0000, 16'h0000);
		add_op("base hi readback", 1'b1, 1'b1, 1'b0, REG_BASE_HI, 16'h0000, {8'h00, NEW_HI});
		add_op("base mid readback", 1'b1, 1'b1, 1'b0, REG_BASE_MID, 16'h0000, {8'h00, NEW_MID});
		add_op("palette0 readback", 1'b1, 1'b1, 1'b0, REG_PALETTE0, 16'h0000, 16'h0000);
		add_op("read lds off", 1'b1, 1'b1, 1'b1, REG_BASE_HI, 16'h0000, 16'h0000);

		repeat (10) @(posedge clk);
		ss <= 1'b0;
		@(negedge clk);
		check_addr("reset vaddr", 23'h008000, vaddr);

		measure_sync(1'b0, H_S, H_TOT);
		measure_sync(1'b1, V_S * H_TOT, FRAME);

		// palette 0 comes out of reset with invert set
		measure_frame("reset base frame", 23'h008000, 1'b1);

		for (int i = 0; i < op_q.size(); i++) begin
			reg_access(op_q[i].bus, dout);
			if (op_q[i].bus.rw) begin
				check_reg(name_q[i], op_q[i].want, dout);
			end
		end

		measure_frame("new base frame", new_base, 1'b0);

		// live address read well before the next rewind
		read_back("vaddr hi readback", REG_VADDR_HI, {8'h00, last[22:15]});
		read_back("vaddr mid readback", REG_VADDR_MID, {8'h00, last[14:7]});
		read_back("vaddr lo readback", REG_VADDR_LO, {8'h00, last[6:0], 1'b0});

		report_and_finish();
	end

endmodule

/* list.f */
logic/video_timing_pkg.sv
logic/video_regs_pkg.sv
logic/video_timing.sv
logic/video_regs.sv
logic/video_fetch.sv
logic/video_shifter.sv
logic/video_top.sv
testbench/tb_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_video \
	-f list.f -o tb_video > build.log 2>&1 \
	|| { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_video > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
